//--- hdl/dispBuf_cfg.svh
// Display buffer configuration
`ifndef DISP_BUF_CFG_SVH
`define DISP_BUF_CFG_SVH

// Words per frame, also the RAM depth
`define FRAME_WORDS 34560

// Field widths
`define READ_ADDR_W 16
`define WRITE_ADDR_W 17
`define HALF_W 32
`define WORD_W 64

`endif

//--- hdl/bufMemPkg.sv
// Buffer memory types
`include "dispBuf_cfg.svh"

package bufMemPkg;

    // Graphics side write address, bit 0 picks the half
    typedef logic [`WRITE_ADDR_W-1:0] writeAddr_t;

    // One 32-bit half of a buffer word
    typedef logic [`HALF_W-1:0] halfWord_t;

    // Full buffer word as seen by the display
    typedef logic [`WORD_W-1:0] bufWord_t;

    // Word index into the buffer
    typedef logic [`WRITE_ADDR_W-2:0] wordIndex_t;

    // Decoded write, ready for the RAM
    typedef struct packed {
        // Set only for an in-frame write
        logic       commit;
        wordIndex_t index;
        // 1 selects bits 63:32
        logic       upperHalf;
        halfWord_t  data;
    } writeCmd_t;

endpackage

//--- hdl/scanPkg.sv
// Display scan types
`include "dispBuf_cfg.svh"

package scanPkg;

    // Scan read address into the buffer
    typedef logic [`READ_ADDR_W-1:0] readAddr_t;

    // Tag that travels with each read
    typedef struct packed {
        readAddr_t addr;
        // High when addr is word zero
        logic      frameStart;
        // Scan has run since reset
        logic      live;
    } scanTag_t;

endpackage

//--- hdl/writeDecode.sv
// Graphics write decode
`include "dispBuf_cfg.svh"

module writeDecode (
    input  logic                  request,
    input  logic                  nRES_L,
    input  logic                  bufWriteEn,
    input  bufMemPkg::writeAddr_t bufWriteAddr,
    input  bufMemPkg::halfWord_t  bufWriteData,
    output bufMemPkg::writeCmd_t  writeCmd
);

    bufMemPkg::wordIndex_t wordIndex;
    logic                  upperSel;
    logic                  inFrame;

    logic                  commitQ;
    bufMemPkg::wordIndex_t indexQ;
    logic                  upperQ;
    bufMemPkg::halfWord_t  dataQ;

    // Address bit 0 selects the half, the rest is the word
    assign wordIndex = bufWriteAddr[`WRITE_ADDR_W-1:1];
    assign upperSel  = bufWriteAddr[0];

    // Writes past the last frame word are dropped here
    assign inFrame = (wordIndex < `FRAME_WORDS);

    // Pending commit flag
    always_ff @(posedge request or posedge nRES_L) begin
        if (nRES_L) begin
            commitQ <= 1'b0;
        end else begin
            commitQ <= bufWriteEn && inFrame;
        end
    end

    // Write payload, only meaningful with commitQ
    always_ff @(posedge request) begin
        indexQ <= wordIndex;
        upperQ <= upperSel;
        dataQ  <= bufWriteData;
    end

    assign writeCmd.commit    = commitQ;
    assign writeCmd.index     = indexQ;
    assign writeCmd.upperHalf = upperQ;
    assign writeCmd.data      = dataQ;

endmodule

//--- hdl/scanAddressGen.sv
// Frame scan address counter
`include "dispBuf_cfg.svh"

module scanAddressGen (
    input  logic             request,
    input  logic             nRES_L,
    output scanPkg::scanTag_t scanTag
);

    scanPkg::readAddr_t addrQ;
    scanPkg::readAddr_t addrNext;
    logic               frameStartQ;
    logic               liveQ;

    // First edge after reset holds word 0 and only raises live
    always_comb begin
        if (!liveQ) begin
            addrNext = '0;
        end else if (addrQ == scanPkg::readAddr_t'(`FRAME_WORDS - 1)) begin
            addrNext = '0;
        end else begin
            addrNext = addrQ + 1'b1;
        end
    end

    always_ff @(posedge request or posedge nRES_L) begin
        if (nRES_L) begin
            addrQ       <= '0;
            frameStartQ <= 1'b0;
            liveQ       <= 1'b0;
        end else begin
            addrQ       <= addrNext;
            frameStartQ <= (addrNext == '0);
            liveQ       <= 1'b1;
        end
    end

    assign scanTag.addr       = addrQ;
    assign scanTag.frameStart = frameStartQ;
    assign scanTag.live       = liveQ;

endmodule

//--- hdl/frameBufferRam.sv
// Display frame buffer RAM
`include "dispBuf_cfg.svh"

module frameBufferRam (
    input  logic                 request,
    input  logic                 nRES_L,
    input  bufMemPkg::writeCmd_t writeCmd,
    input  scanPkg::scanTag_t    scanTag,
    output bufMemPkg::bufWord_t  readWord,
    output scanPkg::scanTag_t    readTag
);

    bufMemPkg::bufWord_t mem [`FRAME_WORDS];

    // Half-word write, index already range checked upstream
    always_ff @(posedge request) begin
        if (writeCmd.commit) begin
            if (writeCmd.upperHalf) begin
                mem[writeCmd.index][`WORD_W-1:`HALF_W] <= writeCmd.data;
            end else begin
                mem[writeCmd.index][`HALF_W-1:0] <= writeCmd.data;
            end
        end
    end

    // Synchronous read, same-word collision returns old data
    always_ff @(posedge request) begin
        readWord <= mem[scanTag.addr];
    end

    // Tag delayed to line up with readWord
    always_ff @(posedge request or posedge nRES_L) begin
        if (nRES_L) begin
            readTag <= '0;
        end else begin
            readTag <= scanTag;
        end
    end

endmodule

//--- hdl/pixelOutput.sv
// Display word output register
module pixelOutput (
    input  logic                request,
    input  logic                nRES_L,
    input  bufMemPkg::bufWord_t readWord,
    input  scanPkg::scanTag_t   readTag,
    output bufMemPkg::bufWord_t pixelWord,
    output logic                pixelValid,
    output logic                frameStart
);

    bufMemPkg::bufWord_t wordQ;
    logic                validQ;
    logic                startQ;

    // Word payload
    always_ff @(posedge request) begin
        wordQ <= readWord;
    end

    // Flags move with the word on the same edge
    always_ff @(posedge request or posedge nRES_L) begin
        if (nRES_L) begin
            validQ <= 1'b0;
            startQ <= 1'b0;
        end else begin
            validQ <= readTag.live;
            startQ <= readTag.frameStart;
        end
    end

    assign pixelWord  = wordQ;
    assign pixelValid = validQ;
    assign frameStart = startQ;

endmodule

//--- hdl/atariDisplayBuf.sv
// Display buffer path top level
module atariDisplayBuf (
    input  logic                  request,
    input  logic                  nRES_L,
    input  logic                  bufWriteEn,
    input  bufMemPkg::writeAddr_t bufWriteAddr,
    input  bufMemPkg::halfWord_t  bufWriteData,
    output bufMemPkg::bufWord_t   pixelWord,
    output logic                  pixelValid,
    output logic                  frameStart
);

    bufMemPkg::writeCmd_t writeCmd;
    scanPkg::scanTag_t    scanTag;
    bufMemPkg::bufWord_t  readWord;
    scanPkg::scanTag_t    readTag;

    // Decode
    writeDecode uWriteDecode (
        .request      (request),
        .nRES_L       (nRES_L),
        .bufWriteEn   (bufWriteEn),
        .bufWriteAddr (bufWriteAddr),
        .bufWriteData (bufWriteData),
        .writeCmd     (writeCmd)
    );

    scanAddressGen uScanAddressGen (
        .request (request),
        .nRES_L  (nRES_L),
        .scanTag (scanTag)
    );

    // Execute
    frameBufferRam uFrameBufferRam (
        .request  (request),
        .nRES_L   (nRES_L),
        .writeCmd (writeCmd),
        .scanTag  (scanTag),
        .readWord (readWord),
        .readTag  (readTag)
    );

    // Result
    pixelOutput uPixelOutput (
        .request    (request),
        .nRES_L     (nRES_L),
        .readWord   (readWord),
        .readTag    (readTag),
        .pixelWord  (pixelWord),
        .pixelValid (pixelValid),
        .frameStart (frameStart)
    );

endmodule

//--- test/atariDisplayBuf_assert.sv
// Display buffer assertions
`include "dispBuf_cfg.svh"

module atariDisplayBuf_assert (
    input logic                 request,
    input logic                 nRES_L,
    input logic                 pixelValid,
    input logic                 frameStart,
    input bufMemPkg::writeCmd_t writeCmd,
    input scanPkg::scanTag_t    scanTag
);

    int   sinceStart;
    logic seenStart;

    // Edges since the last frame marker
    always_ff @(posedge request or posedge nRES_L) begin
        if (nRES_L) begin
            sinceStart <= 0;
            seenStart  <= 1'b0;
        end else if (frameStart) begin
            sinceStart <= 1;
            seenStart  <= 1'b1;
        end else begin
            sinceStart <= sinceStart + 1;
        end
    end

    startNeedsValid: assert property (@(posedge request) disable iff (nRES_L)
        frameStart |-> pixelValid)
        else $error("frameStart high while pixelValid is low");

    commitInFrame: assert property (@(posedge request) disable iff (nRES_L)
        writeCmd.commit |-> (writeCmd.index < `FRAME_WORDS))
        else $error("committed write index %0d is past the frame", writeCmd.index);

    scanInFrame: assert property (@(posedge request) disable iff (nRES_L)
        scanTag.addr < `FRAME_WORDS)
        else $error("scan address %0d is past the frame", scanTag.addr);

    startSpacing: assert property (@(posedge request) disable iff (nRES_L)
        (frameStart && seenStart) |-> (sinceStart >= `FRAME_WORDS))
        else $error("frameStart pulses only %0d cycles apart", sinceStart);

endmodule

bind atariDisplayBuf atariDisplayBuf_assert uAssert (
    .request    (request),
    .nRES_L     (nRES_L),
    .pixelValid (pixelValid),
    .frameStart (frameStart),
    .writeCmd   (writeCmd),
    .scanTag    (scanTag)
);

//--- test/atariDisplayBufTb.sv
// Display buffer testbench
`include "dispBuf_cfg.svh"

module atariDisplayBufTb;

    typedef struct packed {
        logic [3:0]            testId;
        logic                  en;
        bufMemPkg::writeAddr_t addr;
        bufMemPkg::halfWord_t  data;
    } stimEntry_t;

    logic                  request;
    logic                  nRES_L;
    logic                  bufWriteEn;
    bufMemPkg::writeAddr_t bufWriteAddr;
    bufMemPkg::halfWord_t  bufWriteData;
    bufMemPkg::bufWord_t   pixelWord;
    logic                  pixelValid;
    logic                  frameStart;

    // Stimulus table and the buffer contents it implies
    stimEntry_t            stimTable [$];
    bufMemPkg::bufWord_t   expWord [`FRAME_WORDS];
    logic [1:0]            known [`FRAME_WORDS];
    int                    owner [`FRAME_WORDS];
    int                    wordsPerTest [7];
    int                    totalWords;

    logic [31:0]           lfsrState;
    int                    errors [7];
    int                    checks [7];
    int                    passCount;
    int                    failCount;
    int                    totalErrors;
    int                    cycleCount;
    int                    cycleLimit;

    // Scan tracker state
    int                    flowTest;
    int                    resetTest;
    logic                  firstSample;
    int                    edgeCnt;
    logic                  haveStart;
    int                    sinceStart;
    int                    startCount;
    int                    firstWords;
    logic                  checkArmed;
    logic                  checkOn;
    int                    checkedFrames;
    scanPkg::readAddr_t    scanWord;
    int                    wordTest;

    atariDisplayBuf DUT (
        .request      (request),
        .nRES_L       (nRES_L),
        .bufWriteEn   (bufWriteEn),
        .bufWriteAddr (bufWriteAddr),
        .bufWriteData (bufWriteData),
        .pixelWord    (pixelWord),
        .pixelValid   (pixelValid),
        .frameStart   (frameStart)
    );

    always #5 request = ~request;

    // Right-shifting Galois LFSR
    function automatic logic [31:0] lfsrNext(input logic [31:0] state);
        if (state[0]) begin
            return (state >> 1) ^ 32'hB4BC_D35C;
        end
        return state >> 1;
    endfunction

    function automatic bufMemPkg::halfWord_t randomHalf();
        bufMemPkg::halfWord_t bits;
        bits = '0;
        for (int i = 0; i < `HALF_W; i++) begin
            lfsrState = lfsrNext(lfsrState);
            bits = {bits[`HALF_W-2:0], lfsrState[0]};
        end
        return bits;
    endfunction

    function automatic bufMemPkg::writeAddr_t halfAddr(input int index, input logic upper);
        return {index[`WRITE_ADDR_W-2:0], upper};
    endfunction

    task automatic addEntry(input int testId, input logic en, input int index,
                            input logic upper);
        stimEntry_t entry;
        entry.testId = testId[3:0];
        entry.en     = en;
        entry.addr   = halfAddr(index, upper);
        entry.data   = randomHalf();
        stimTable.push_back(entry);
    endtask

    task automatic buildTable();
        int halfWords [5];
        halfWords = '{0, 1, 2, 100, 34559};
        // Both halves with the low half first
        for (int i = 0; i < 5; i++) begin
            addEntry(3, 1'b1, halfWords[i], 1'b0);
            addEntry(3, 1'b1, halfWords[i], 1'b1);
        end
        addEntry(3, 1'b1, 17280, 1'b1);
        addEntry(3, 1'b1, 17280, 1'b0);
        // Repeated writes where the later data must stay
        addEntry(4, 1'b1, 5, 1'b0);
        addEntry(4, 1'b1, 5, 1'b1);
        addEntry(4, 1'b1, 5, 1'b0);
        addEntry(4, 1'b1, 5, 1'b1);
        addEntry(4, 1'b1, 200, 1'b1);
        addEntry(4, 1'b1, 200, 1'b0);
        addEntry(4, 1'b1, 200, 1'b1);
        // Victims for dropped writes at index mod 2^15 and mod frame
        addEntry(5, 1'b1, 1792, 1'b0);
        addEntry(5, 1'b1, 1792, 1'b1);
        addEntry(5, 1'b1, 30975, 1'b0);
        addEntry(5, 1'b1, 30975, 1'b1);
        addEntry(5, 1'b1, 32767, 1'b0);
        addEntry(5, 1'b1, 32767, 1'b1);
        addEntry(5, 1'b0, 1792, 1'b0);
        addEntry(5, 1'b0, 1792, 1'b1);
        addEntry(5, 1'b1, 34560, 1'b0);
        addEntry(5, 1'b1, 34560, 1'b1);
        addEntry(5, 1'b1, 36352, 1'b0);
        addEntry(5, 1'b1, 65535, 1'b0);
        addEntry(5, 1'b1, 65535, 1'b1);
    endtask

    // Expected words from the write rules
    task automatic buildExpected();
        int idx;
        for (int w = 0; w < `FRAME_WORDS; w++) begin
            known[w]   = 2'b00;
            expWord[w] = '0;
            owner[w]   = 0;
        end
        foreach (stimTable[i]) begin
            idx = int'(stimTable[i].addr[`WRITE_ADDR_W-1:1]);
            if (stimTable[i].en && idx < `FRAME_WORDS) begin
                if (stimTable[i].addr[0]) begin
                    expWord[idx][`WORD_W-1:`HALF_W] = stimTable[i].data;
                    known[idx][1] = 1'b1;
                end else begin
                    expWord[idx][`HALF_W-1:0] = stimTable[i].data;
                    known[idx][0] = 1'b1;
                end
                owner[idx] = int'(stimTable[i].testId);
            end
        end
        for (int w = 0; w < `FRAME_WORDS; w++) begin
            if (known[w] == 2'b11) begin
                wordsPerTest[owner[w]]++;
                totalWords++;
            end
        end
    endtask

    task automatic reportTest(input int id, input string name);
        if (errors[id] == 0) begin
            passCount++;
            $display("PASS test %0d, %s", id, name);
        end else begin
            failCount++;
            $display("FAIL test %0d, %s, %0d errors", id, name, errors[id]);
        end
    endtask

    // Scan tracker sampling the outputs settled since the last edge
    always @(posedge request) begin
        if (nRES_L) begin
            if (!firstSample && (pixelValid || frameStart)) begin
                $display("Mismatch at time %0t: pixelValid %b frameStart %b in reset",
                         $time, pixelValid, frameStart);
                errors[resetTest]++;
            end
            firstSample = 1'b0;
            edgeCnt     = 0;
            haveStart   = 1'b0;
            sinceStart  = 0;
            checkOn     = 1'b0;
        end else begin
            if (edgeCnt < 3 && (pixelValid || frameStart)) begin
                $display("Mismatch at time %0t: output flags high %0d edges after reset",
                         $time, edgeCnt);
                errors[resetTest]++;
            end
            if (edgeCnt == 3) begin
                if (!(pixelValid && frameStart)) begin
                    $display("Mismatch at time %0t: first word lacks pixelValid or frameStart",
                             $time);
                    errors[resetTest]++;
                end
                firstWords++;
            end
            if (edgeCnt > 3 && !pixelValid) begin
                $display("Mismatch at time %0t: pixelValid dropped while scanning", $time);
                errors[flowTest]++;
            end
            edgeCnt++;
            if (haveStart) begin
                sinceStart++;
            end
            if (frameStart) begin
                if (haveStart && sinceStart != `FRAME_WORDS) begin
                    $display("Mismatch at time %0t: frameStart spacing %0d, expected %0d",
                             $time, sinceStart, `FRAME_WORDS);
                    errors[flowTest]++;
                end
                haveStart  = 1'b1;
                sinceStart = 0;
                startCount++;
                if (checkOn) begin
                    checkOn = 1'b0;
                    checkedFrames++;
                end
                if (checkArmed) begin
                    checkOn    = 1'b1;
                    checkArmed = 1'b0;
                end
            end else if (haveStart && sinceStart == `FRAME_WORDS) begin
                $display("Error at time %0t: no frameStart after a full frame of words", $time);
                errors[flowTest]++;
            end
            if (checkOn && sinceStart < `FRAME_WORDS) begin
                scanWord = scanPkg::readAddr_t'(sinceStart);
                if (known[scanWord] == 2'b11) begin
                    wordTest = (flowTest == 6) ? 6 : owner[scanWord];
                    checks[wordTest]++;
                    if (pixelWord !== expWord[scanWord]) begin
                        $display("Mismatch at time %0t: word %0d is %h, expected %h",
                                 $time, scanWord, pixelWord, expWord[scanWord]);
                        errors[wordTest]++;
                    end
                end
            end
        end
    end

    // Watchdog
    always @(posedge request) begin
        cycleCount++;
        if (cycleCount >= cycleLimit) begin
            $display("Timeout after %0d cycles, the scan did not reach its next frame",
                     cycleCount);
            $display("Test failed");
            $finish;
        end
    end

    initial begin
        request      = 1'b0;
        nRES_L       = 1'b1;
        bufWriteEn   = 1'b0;
        bufWriteAddr = '0;
        bufWriteData = '0;
        lfsrState    = 32'd49;
        totalWords   = 0;
        passCount    = 0;
        failCount    = 0;
        totalErrors  = 0;
        cycleCount   = 0;
        flowTest     = 1;
        resetTest    = 1;
        firstSample  = 1'b1;
        edgeCnt      = 0;
        haveStart    = 1'b0;
        sinceStart   = 0;
        startCount   = 0;
        firstWords   = 0;
        checkArmed   = 1'b0;
        checkOn      = 1'b0;
        checkedFrames = 0;
        for (int t = 0; t < 7; t++) begin
            errors[t]       = 0;
            checks[t]       = 0;
            wordsPerTest[t] = 0;
        end
        buildTable();
        buildExpected();
        cycleLimit = 4 * `FRAME_WORDS + stimTable.size() + 2000;

        // Load the buffer while the first frame scans
        repeat (5) @(negedge request);
        nRES_L = 1'b0;
        foreach (stimTable[i]) begin
            bufWriteEn   = stimTable[i].en;
            bufWriteAddr = stimTable[i].addr;
            bufWriteData = stimTable[i].data;
            @(negedge request);
        end
        bufWriteEn = 1'b0;
        wait (firstWords >= 1);
        reportTest(1, "reset and first word");

        repeat (3) @(negedge request);
        checkArmed = 1'b1;
        flowTest   = 2;
        wait (startCount >= 2);
        reportTest(2, "frame wrap");

        flowTest = 3;
        wait (checkedFrames >= 1);
        for (int t = 3; t <= 5; t++) begin
            if (checks[t] != wordsPerTest[t]) begin
                $display("Error: test %0d compared %0d of its %0d words",
                         t, checks[t], wordsPerTest[t]);
                errors[t]++;
            end
        end
        reportTest(3, "half writes");
        reportTest(4, "last write wins");
        reportTest(5, "out-of-frame writes");

        // Reset in the middle of a frame
        repeat (1000) @(negedge request);
        flowTest  = 6;
        resetTest = 6;
        nRES_L    = 1'b1;
        repeat (5) @(negedge request);
        checkArmed = 1'b1;
        nRES_L     = 1'b0;
        wait (checkedFrames >= 2);
        if (firstWords != 2) begin
            $display("Error: scan did not restart with a fresh first word after reset");
            errors[6]++;
        end
        if (checks[6] != totalWords) begin
            $display("Error: only %0d of %0d written words were read back after reset",
                     checks[6], totalWords);
            errors[6]++;
        end
        reportTest(6, "reset during scanning");

        for (int t = 0; t < 7; t++) begin
            totalErrors += errors[t];
        end
        $display("Summary: %0d tests passed, %0d failed, %0d errors",
                 passCount, failCount, totalErrors);
        if (failCount == 0 && totalErrors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

//--- atariDisplayBuf.f
+incdir+hdl
hdl/bufMemPkg.sv
hdl/scanPkg.sv
hdl/writeDecode.sv
hdl/scanAddressGen.sv
hdl/frameBufferRam.sv
hdl/pixelOutput.sv
hdl/atariDisplayBuf.sv
test/atariDisplayBuf_assert.sv
test/atariDisplayBufTb.sv

//--- run.sh
#!/bin/sh
# Compile and run the display buffer testbench with Verilator

cd "$(dirname "$0")" || exit 1

OBJ_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module atariDisplayBufTb --Mdir "$OBJ_DIR" -o simv \
    -f atariDisplayBuf.f
if [ $? -ne 0 ]; then
    echo "Verilator compile failed"
    exit 1
fi

"./$OBJ_DIR/simv" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Test failed" "$LOG"; then
    echo "FAIL: see $LOG"
    exit 1
fi

echo "PASS"
exit 0
